//--- design/apb_bridge_config.svh
`ifndef APB_BRIDGE_CONFIG_SVH
`define APB_BRIDGE_CONFIG_SVH

// Bus widths.
`define W_HADDR 32
`define W_PADDR 16
`define W_DATA 32

// Field of paddr that picks the peripheral.
`define REGION_MSB 15
`define REGION_LSB 12

// Words per register file; the last one is the read-only ID.
`define REGFILE_WORDS 8

`endif

//--- design/ahbl_pkg.sv
`default_nettype none

package ahbl_pkg;

	// Transfer type of an AHB-Lite address phase.
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Response of a data phase.
	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_t;

endpackage

`default_nettype wire

//--- design/apb_pkg.sv
`default_nettype none

package apb_pkg;

	// State of the AHB-Lite to APB bridge.
	typedef enum logic [2:0] {
		RD_SETUP  = 3'h0,
		RD_ACCESS = 3'h1,
		WR_SETUP  = 3'h2,
		WR_ACCESS = 3'h3,
		IDLE      = 3'h4
	} bridge_state_t;

	// Peripheral picked by the region field of paddr.
	typedef enum logic [1:0] {
		REGION_RF0  = 2'd0,
		REGION_RF1  = 2'd1,
		REGION_NONE = 2'd2
	} apb_region_t;

endpackage

`default_nettype wire

//--- design/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

interface apb_if;

	logic [`W_PADDR-1:0] paddr;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [`W_DATA-1:0]  pwdata;
	logic                pready;
	logic [`W_DATA-1:0]  prdata;
	logic                pslverr;

	modport master (
		output paddr, psel, penable, pwrite, pwdata,
		input  pready, prdata, pslverr
	);

	modport slave (
		input  paddr, psel, penable, pwrite, pwdata,
		output pready, prdata, pslverr
	);

endinterface

`default_nettype wire

//--- design/ahbl_to_apb.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

module ahbl_to_apb (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 hready,
	output logic                 hready_resp,
	output ahbl_pkg::hresp_t     hresp,
	input  logic [`W_HADDR-1:0]  haddr,
	input  logic                 hwrite,
	input  ahbl_pkg::htrans_t    htrans,
	input  logic [`W_DATA-1:0]   hwdata,
	output logic [`W_DATA-1:0]   hrdata,

	apb_if.master                apb
);

	import ahbl_pkg::*;
	import apb_pkg::*;

	bridge_state_t state;
	logic          in_access;
	logic          active;

	assign active = (htrans == NONSEQ) || (htrans == SEQ);
	assign in_access = (state == RD_ACCESS) || (state == WR_ACCESS);

	// The data phase ends when APB completes, or at once if nothing is pending.
	assign hready_resp = (in_access && apb.pready) || (state == apb_pkg::IDLE);
	assign hrdata = apb.prdata;
	assign hresp = apb.pslverr ? ERROR : OKAY;

	always_comb begin
		case (state)
			RD_SETUP: begin
				apb.psel = 1'b1;
				apb.penable = 1'b0;
				apb.pwrite = 1'b0;
			end
			RD_ACCESS: begin
				apb.psel = 1'b1;
				apb.penable = 1'b1;
				apb.pwrite = 1'b0;
			end
			WR_SETUP: begin
				apb.psel = 1'b1;
				apb.penable = 1'b0;
				apb.pwrite = 1'b1;
			end
			WR_ACCESS: begin
				apb.psel = 1'b1;
				apb.penable = 1'b1;
				apb.pwrite = 1'b1;
			end
			default: begin
				apb.psel = 1'b0;
				apb.penable = 1'b0;
				apb.pwrite = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= apb_pkg::IDLE;
			apb.paddr <= '0;
		end else begin
			if (state == WR_SETUP)
				state <= WR_ACCESS;
			if (state == RD_SETUP)
				state <= RD_ACCESS;
			// hready is low in setup and in a stalled access, so this only fires at a boundary.
			if (hready) begin
				if (active) begin
					apb.paddr <= haddr[`W_PADDR-1:0];
					state <= hwrite ? WR_SETUP : RD_SETUP;
				end else begin
					state <= apb_pkg::IDLE;
				end
			end
		end
	end

	// Write data arrives in the AHB data phase, which is the APB setup cycle.
	always_ff @(posedge clk) begin
		if (state == WR_SETUP)
			apb.pwdata <= hwdata;
	end

endmodule

`default_nettype wire

//--- design/apb_splitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

module apb_splitter (
	apb_if.slave  upstream,
	apb_if.master rf0,
	apb_if.master rf1
);

	import apb_pkg::*;

	localparam integer W_REGION = `REGION_MSB - `REGION_LSB + 1;

	logic [W_REGION-1:0] field;
	apb_region_t         region;

	assign field = upstream.paddr[`REGION_MSB:`REGION_LSB];

	always_comb begin
		if (field == W_REGION'(0))
			region = REGION_RF0;
		else if (field == W_REGION'(1))
			region = REGION_RF1;
		else
			region = REGION_NONE;
	end

	// Requests go to both peripherals; only psel is steered.
	assign rf0.paddr = upstream.paddr;
	assign rf0.penable = upstream.penable;
	assign rf0.pwrite = upstream.pwrite;
	assign rf0.pwdata = upstream.pwdata;
	assign rf0.psel = upstream.psel && (region == REGION_RF0);

	assign rf1.paddr = upstream.paddr;
	assign rf1.penable = upstream.penable;
	assign rf1.pwrite = upstream.pwrite;
	assign rf1.pwdata = upstream.pwdata;
	assign rf1.psel = upstream.psel && (region == REGION_RF1);

	always_comb begin
		case (region)
			REGION_RF0: begin
				upstream.pready = rf0.pready;
				upstream.prdata = rf0.prdata;
				upstream.pslverr = rf0.pslverr;
			end
			REGION_RF1: begin
				upstream.pready = rf1.pready;
				upstream.prdata = rf1.prdata;
				upstream.pslverr = rf1.pslverr;
			end
			default: begin
				// Nothing lives here. Fail at the first access cycle.
				upstream.pready = 1'b1;
				upstream.prdata = '0;
				upstream.pslverr = upstream.psel && upstream.penable;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/apb_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

module apb_regfile #(
	parameter integer             WAIT_STATES = 0,
	parameter logic [`W_DATA-1:0] ID_VALUE = '0
) (
	input  logic  clk,
	input  logic  rst_n,
	apb_if.slave  apb
);

	localparam integer W_IDX = $clog2(`REGFILE_WORDS);
	localparam integer W_CNT = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [W_CNT-1:0] CNT_LAST = W_CNT'(WAIT_STATES);
	localparam logic [W_IDX-1:0] ID_IDX = W_IDX'(`REGFILE_WORDS - 1);

	logic [`W_DATA-1:0] regs [0:`REGFILE_WORDS-2];
	logic [W_CNT-1:0]   wait_cnt;
	logic [W_IDX-1:0]   idx;
	logic               is_id;
	logic               done;

	assign idx = apb.paddr[W_IDX+1:2];
	assign is_id = (idx == ID_IDX);
	assign done = apb.psel && apb.penable && (wait_cnt == CNT_LAST);

	assign apb.pready = done;
	assign apb.pslverr = done && apb.pwrite && is_id; // The ID word is read-only.

	always_comb begin
		if (is_id)
			apb.prdata = ID_VALUE;
		else
			apb.prdata = regs[idx];
	end

	// Counts access cycles; cleared between transfers so back-to-back ones wait again.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (!apb.psel || done)
			wait_cnt <= '0;
		else if (apb.penable)
			wait_cnt <= wait_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REGFILE_WORDS - 1; i++)
				regs[i] <= '0;
		end else if (done && apb.pwrite && !is_id) begin
			regs[idx] <= apb.pwdata;
		end
	end

endmodule

`default_nettype wire

//--- design/apb_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

module apb_subsystem_top (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 hready,
	output logic                 hready_resp,
	output ahbl_pkg::hresp_t     hresp,
	input  logic [`W_HADDR-1:0]  haddr,
	input  logic                 hwrite,
	input  ahbl_pkg::htrans_t    htrans,
	input  logic [`W_DATA-1:0]   hwdata,
	output logic [`W_DATA-1:0]   hrdata
);

	apb_if apb_bus ();
	apb_if apb_rf0 ();
	apb_if apb_rf1 ();

	ahbl_to_apb bridge_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.hready      (hready),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hwdata      (hwdata),
		.hrdata      (hrdata),
		.apb         (apb_bus.master)
	);

	apb_splitter splitter_inst (
		.upstream (apb_bus.slave),
		.rf0      (apb_rf0.master),
		.rf1      (apb_rf1.master)
	);

	// Zero-wait peripheral at region 0.
	apb_regfile #(
		.WAIT_STATES (0),
		.ID_VALUE    (32'h5246_0000)
	) rf0_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.apb   (apb_rf0.slave)
	);

	// Slower peripheral at region 1.
	apb_regfile #(
		.WAIT_STATES (2),
		.ID_VALUE    (32'h5246_0001)
	) rf1_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.apb   (apb_rf1.slave)
	);

endmodule

`default_nettype wire

//--- bench/apb_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_config.svh"

module apb_subsystem_tb;

	import ahbl_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TRANSACTIONS = 120;
	localparam int RF_WORDS = `REGFILE_WORDS - 1; // Writable words per register file.
	localparam logic [`W_DATA-1:0] ID_RF0 = 32'h5246_0000;
	localparam logic [`W_DATA-1:0] ID_RF1 = 32'h5246_0001;

	logic                clk;
	logic                rst_n;
	logic                hready;
	logic                hready_resp;
	hresp_t              hresp;
	logic [`W_HADDR-1:0] haddr;
	logic                hwrite;
	htrans_t             htrans;
	logic [`W_DATA-1:0]  hwdata;
	logic [`W_DATA-1:0]  hrdata;

	logic [`W_DATA-1:0]  ref_mem [0:1][0:RF_WORDS-1];
	logic [31:0]         lcg_state = 32'h467c_d71c;
	int                  errors;
	int                  checks;

	assign hready = hready_resp; // Only one master, so the bus is free when the slave is.

	apb_subsystem_top apb_subsystem_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.hready      (hready),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hwdata      (hwdata),
		.hrdata      (hrdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TRANSACTIONS * 10 * CLK_PERIOD);
		$display("Timeout: the bus never finished its transfers within the time limit.");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// An error response belongs to the cycle that ends a data phase.
	assert property (@(posedge clk) hresp == ERROR |-> hready_resp)
		else begin
			errors++;
			$display("mismatch at %0t ns: hresp is ERROR while hready_resp is low", $time);
		end

	assert property (@(posedge clk) !rst_n |-> (hready_resp && hresp == OKAY))
		else begin
			errors++;
			$display("mismatch at %0t ns: bus not idle and OKAY during reset", $time);
		end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [`W_HADDR-1:0] word_addr(input int region, input int word);
		logic [`W_HADDR-1:0] addr;
		addr = '0;
		addr[`REGION_MSB:`REGION_LSB] = region[3:0];
		addr[4:2] = word[2:0];
		return addr;
	endfunction

	// The setup cycle plus the wait states of the peripheral behind the address.
	function automatic int expected_low_cycles(input logic [`W_HADDR-1:0] addr);
		if (addr[`REGION_MSB:`REGION_LSB] == 4'd1)
			return 3;
		else
			return 1;
	endfunction

	task automatic ahb_transfer(
		input  logic                wr,
		input  logic [`W_HADDR-1:0] addr,
		input  logic [`W_DATA-1:0]  wdata,
		output logic [`W_DATA-1:0]  rdata,
		output hresp_t              resp,
		output int                  low_cycles
	);
		@(posedge clk);
		haddr <= addr;
		hwrite <= wr;
		htrans <= NONSEQ;
		@(negedge clk);
		while (!hready_resp)
			@(negedge clk);
		@(posedge clk); // Address phase accepted here.
		htrans <= IDLE;
		hwdata <= wr ? wdata : '0;
		low_cycles = 0;
		@(negedge clk);
		while (!hready_resp) begin
			low_cycles++;
			@(negedge clk);
		end
		rdata = hrdata;
		resp = hresp;
	endtask

	task automatic check_phase_length(input logic [`W_HADDR-1:0] addr, input int low);
		checks++;
		assert (low == expected_low_cycles(addr)) else begin
			errors++;
			$display("mismatch at %0t ns: hready_resp low for %0d cycles at %h, expected %0d",
				$time, low, addr, expected_low_cycles(addr));
		end
	endtask

	task automatic ahb_write(input logic [`W_HADDR-1:0] addr, input logic [`W_DATA-1:0] data);
		logic [`W_DATA-1:0] rdata;
		hresp_t             resp;
		hresp_t             exp_resp;
		int                 low;
		int                 region;
		int                 word;
		region = addr[`REGION_MSB:`REGION_LSB];
		word = addr[4:2];
		exp_resp = (region > 1 || word == RF_WORDS) ? ERROR : OKAY;
		ahb_transfer(1'b1, addr, data, rdata, resp, low);
		checks++;
		assert (resp == exp_resp) else begin
			errors++;
			$display("mismatch at %0t ns: write to %h answered %s, expected %s",
				$time, addr, resp.name(), exp_resp.name());
		end
		if (region > 1) begin
			checks++;
			assert (rdata == '0) else begin
				errors++;
				$display("mismatch at %0t ns: unmapped write to %h shows data %h",
					$time, addr, rdata);
			end
		end
		check_phase_length(addr, low);
		if (exp_resp == OKAY)
			ref_mem[region][word] = data;
	endtask

	task automatic ahb_read(input logic [`W_HADDR-1:0] addr);
		logic [`W_DATA-1:0] rdata;
		logic [`W_DATA-1:0] exp_data;
		hresp_t             resp;
		hresp_t             exp_resp;
		int                 low;
		int                 region;
		int                 word;
		region = addr[`REGION_MSB:`REGION_LSB];
		word = addr[4:2];
		if (region > 1) begin
			exp_data = '0;
			exp_resp = ERROR;
		end else if (word == RF_WORDS) begin
			exp_data = (region == 0) ? ID_RF0 : ID_RF1;
			exp_resp = OKAY;
		end else begin
			exp_data = ref_mem[region][word];
			exp_resp = OKAY;
		end
		ahb_transfer(1'b0, addr, '0, rdata, resp, low);
		checks++;
		assert (rdata == exp_data && resp == exp_resp) else begin
			errors++;
			$display("mismatch at %0t ns: read of %h gave %h %s, expected %h %s",
				$time, addr, rdata, resp.name(), exp_data, exp_resp.name());
		end
		check_phase_length(addr, low);
	endtask

	// An IDLE or BUSY with write data that must not reach any register.
	task automatic idle_transfer(
		input htrans_t             kind,
		input logic [`W_HADDR-1:0] addr,
		input logic [`W_DATA-1:0]  wdata
	);
		@(posedge clk);
		haddr <= addr;
		hwrite <= 1'b1;
		htrans <= kind;
		@(negedge clk);
		while (!hready_resp)
			@(negedge clk);
		@(posedge clk);
		htrans <= IDLE;
		hwdata <= wdata;
		@(negedge clk);
		checks++;
		assert (hready_resp && hresp == OKAY) else begin
			errors++;
			$display("mismatch at %0t ns: %s transfer at %h did not finish at once with OKAY",
				$time, kind.name(), addr);
		end
	endtask

	initial begin
		logic [31:0] r;
		int          region;
		int          word;
		rst_n = 1'b1;
		haddr = '0;
		hwrite = 1'b0;
		htrans = IDLE;
		hwdata = '0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 2; i++)
			for (int j = 0; j < RF_WORDS; j++)
				ref_mem[i][j] = '0; // Register files reset to zero.
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		repeat (5) begin
			@(negedge clk);
			checks++;
			assert (hready_resp && hresp == OKAY) else begin
				errors++;
				$display("mismatch at %0t ns: bus not ready and OKAY while idle", $time);
			end
		end

		for (int i = 0; i < 40; i++) begin
			r = next_random();
			region = r[1];
			word = r[10:8] % RF_WORDS;
			if (i < 14 || (i % 2) == 0)
				ahb_write(word_addr(region, word), next_random());
			else
				ahb_read(word_addr(region, word));
		end

		// Regions 2 to 15 have no peripheral.
		for (int reg_id = 2; reg_id < 16; reg_id++) begin
			ahb_write(word_addr(reg_id, reg_id % RF_WORDS), next_random());
			ahb_read(word_addr(reg_id, (reg_id + 3) % RF_WORDS));
		end
		for (int i = 0; i < 2; i++)
			for (int j = 0; j < RF_WORDS; j++)
				ahb_read(word_addr(i, j));

		for (int i = 0; i < 2; i++) begin
			ahb_read(word_addr(i, RF_WORDS));
			ahb_write(word_addr(i, RF_WORDS), next_random());
			ahb_read(word_addr(i, RF_WORDS));
		end

		for (int i = 0; i < 8; i++) begin
			r = next_random();
			region = r[1];
			word = r[10:8] % RF_WORDS;
			ahb_write(word_addr(region, word), next_random());
			idle_transfer(r[2] ? BUSY : IDLE, word_addr(region, word), next_random());
			ahb_read(word_addr(region, word));
		end

		@(posedge clk);
		$display("Checks run: %0d, errors found: %0d.", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/ahbl_pkg.sv
design/apb_pkg.sv
design/apb_if.sv
design/ahbl_to_apb.sv
design/apb_splitter.sv
design/apb_regfile.sv
design/apb_subsystem_top.sv
bench/apb_subsystem_tb.sv
